// ==== project.f ====
+incdir+.
crc_lane_pkg.sv
crc_lane_ifs.sv
pkt_crc_fsm.sv
byte_remain_counter.sv
crc_data_prep.sv
crc32_engine.sv
crc_gen_lane.sv
tb_crc_gen_lane.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the lane with its testbench, run it and judge the run from the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_crc_gen_lane \
    -f project.f -o sim_crc_gen_lane > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/sim_crc_gen_lane > sim.log 2>&1 ; cat sim.log
grep -q "^Result: PASSED$" sim.log && exit 0 || exit 1

// ==== tb_crc_gen_lane.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "crc_lane_defs.svh"

module tb_crc_gen_lane;

    localparam int MAX_CYCLES = 3000;

    logic                   clk;
    logic                   rst_n = 1'b0;
    logic                   crc_gen_dis;
    logic                   link_up;
    logic                   in_tunnel_mode_en;
    logic                   in_header_en;
    logic [`IDI_DT_W-1:0]   in_data_type;
    logic [`IDI_WC_W-1:0]   in_word_count;
    logic [`IDI_VC_W-1:0]   in_virtual_channel;
    logic [`IDI_DATA_W-1:0] in_data;
    logic                   in_data_en;
    logic [`IDI_BE_W-1:0]   in_byte_en;
    logic                   out_tunnel_mode_en;
    logic                   out_header_en;
    logic [`IDI_DT_W-1:0]   out_data_type;
    logic [`IDI_WC_W-1:0]   out_word_count;
    logic [`IDI_VC_W-1:0]   out_virtual_channel;
    logic [`IDI_DATA_W-1:0] out_data;
    logic                   out_data_en;
    logic [`IDI_BE_W-1:0]   out_byte_en;
    logic                   pkt_crc_en;
    logic [`CRC_W-1:0]      pkt_crc;

    logic [31:0] lfsr;
    logic [7:0]  byte_q[$];
    logic [31:0] exp_crc;
    logic        crc_due;
    logic [95:0] in_bus_d;
    logic        out_hdr_d;
    int          errors;
    int          errors_mark;
    int          tests;
    int          cycles;

    wire [95:0] in_bus  = {in_tunnel_mode_en, in_header_en, in_data_type, in_word_count,
                           in_virtual_channel, in_data, in_data_en, in_byte_en};
    wire [95:0] out_bus = {out_tunnel_mode_en, out_header_en, out_data_type, out_word_count,
                           out_virtual_channel, out_data, out_data_en, out_byte_en};

    crc_gen_lane DUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Inputs and output header delayed by one edge for the checks at the falling edge
    always @(posedge clk) begin
        in_bus_d  <= in_bus;
        out_hdr_d <= out_header_en;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Run stopped at the cycle limit of %0d", MAX_CYCLES);
            $display("Result: FAILED");
            $finish;
        end
    end

    pass_through: assert property (@(negedge clk) disable iff (!rst_n) out_bus == in_bus_d)
        else begin
            errors++;
            $display("CHECK FAILED out_bus: got %h expected %h", out_bus, in_bus_d);
        end

    crc_aligned: assert property (@(negedge clk) disable iff (!rst_n)
                                  !pkt_crc_en || (out_hdr_d && !out_header_en))
        else begin
            errors++;
            $display("pkt_crc_en is high away from the falling edge of out_header_en");
        end

    crc_match: assert property (@(negedge clk) disable iff (!rst_n)
                                !pkt_crc_en || pkt_crc == exp_crc)
        else begin
            errors++;
            $display("CHECK FAILED pkt_crc: got %h expected %h", pkt_crc, exp_crc);
        end

    crc_owed: assert property (@(negedge clk) disable iff (!rst_n) !pkt_crc_en || crc_due)
        else begin
            errors++;
            $display("pkt_crc_en pulsed where no long packet ended");
        end

    crc_off: assert property (@(negedge clk) disable iff (!rst_n)
                              !crc_gen_dis || (!pkt_crc_en && pkt_crc == '0))
        else begin
            errors++;
            $display("CHECK FAILED pkt_crc_en/pkt_crc: got %h/%h expected %h/%h while disabled",
                     pkt_crc_en, pkt_crc, 1'b0, 32'h0);
        end

    // Taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    // Bit-serial CRC-32 over the payload bytes with each byte taken LSB first
    function automatic logic [31:0] ref_crc();
        logic [31:0] c;
        logic        fb;
        c = `CRC_INIT;
        foreach (byte_q[k]) begin
            for (int b = 0; b < 8; b++) begin
                fb = c[0] ^ byte_q[k][b];
                c = {1'b0, c[31:1]} ^ (fb ? `CRC_POLY : 32'h0);
            end
        end
        return c ^ `CRC_XOR_OUT;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic put_header(input logic [5:0] dt, input logic tun, input logic [15:0] wc);
        next_cycle();
        in_header_en       = 1'b1;
        in_data_en         = 1'b0;
        in_data_type       = dt;
        in_tunnel_mode_en  = tun;
        in_word_count      = wc;
        in_virtual_channel = 4'(rand_bits(4));
        in_byte_en         = 3'(rand_bits(3));
        in_data            = rand_bits(64);
    endtask

    task automatic wait_crc(input logic want);
        int   n;
        logic seen;
        n = 0;
        seen = 1'b0;
        while (!seen && n < 4) begin
            @(negedge clk);
            seen = pkt_crc_en;
            n++;
        end
        assert (!want || seen)
            else begin
                errors++;
                $display("No pkt_crc_en pulse after the end of a long packet");
            end
        next_cycle();
        crc_due = 1'b0;
    endtask

    task automatic send_long(input logic [5:0] dt, input logic tun, input logic [15:0] wc,
                             input logic want);
        int          remain;
        logic        swap;
        logic [63:0] d;
        remain = int'(wc);
        swap = (dt == `DT_SWAP_A) || (dt == `DT_SWAP_B) || tun;
        byte_q.delete();
        put_header(dt, tun, wc);
        while (remain > 0) begin
            next_cycle();
            d = rand_bits(64);
            in_data_en = 1'b1;
            in_data = d;
            for (int i = 0; i < 8 && i < remain; i++)
                byte_q.push_back(swap ? d[(7-i)*8 +: 8] : d[i*8 +: 8]);
            remain -= (remain > 8) ? 8 : remain;
        end
        next_cycle();
        in_header_en = 1'b0;
        in_data_en = 1'b0;
        exp_crc = ref_crc();
        crc_due = want;
        wait_crc(want);
    endtask

    task automatic send_short(input logic [5:0] dt);
        put_header(dt, 1'b0, 16'(rand_bits(16)));
        next_cycle();
        in_header_en = 1'b0;
        wait_crc(1'b0);
    endtask

    // The link falls on the third payload beat and the packet is lost
    task automatic drop_link();
        put_header(6'h2a, 1'b0, 16'd32);
        for (int i = 0; i < 3; i++) begin
            next_cycle();
            in_data_en = 1'b1;
            in_data = rand_bits(64);
        end
        link_up = 1'b0;
        next_cycle();
        in_header_en = 1'b0;
        in_data_en = 1'b0;
        repeat (3) next_cycle();
        link_up = 1'b1;
        wait_crc(1'b0);
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("Test %0d %s: %0d failed checks", tests, name, errors - errors_mark);
        errors_mark = errors;
    endtask

    initial begin
        crc_gen_dis = 1'b0;
        link_up = 1'b0;
        in_tunnel_mode_en = 1'b0;
        in_header_en = 1'b0;
        in_data_type = '0;
        in_word_count = '0;
        in_virtual_channel = '0;
        in_data = '0;
        in_data_en = 1'b0;
        in_byte_en = '0;
        lfsr = 32'hdf81;
        exp_crc = '0;
        crc_due = 1'b0;
        errors = 0;
        errors_mark = 0;
        tests = 0;
        cycles = 0;
        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;
        link_up = 1'b1;
        repeat (2) next_cycle();
        send_long(6'h2a, 1'b0, 16'd8, 1'b1);
        send_long(6'h2a, 1'b0, 16'd16, 1'b1);
        send_long(6'h2a, 1'b0, 16'd40, 1'b1);
        finish_test("full beats");
        send_long(6'h2a, 1'b0, 16'd13, 1'b1);
        send_long(6'h2b, 1'b0, 16'd3, 1'b1);
        send_long(6'h2a, 1'b0, 16'd21, 1'b1);
        finish_test("partial last beat");
        send_long(6'h1a, 1'b0, 16'd24, 1'b1);
        send_long(6'h1e, 1'b0, 16'd12, 1'b1);
        send_long(6'h24, 1'b1, 16'd20, 1'b1);
        send_long(6'h2a, 1'b0, 16'd11, 1'b1);
        finish_test("byte swap");
        send_short(6'h01);
        send_short(6'h02);
        finish_test("short packets");
        crc_gen_dis = 1'b1;
        send_long(6'h2a, 1'b0, 16'd16, 1'b0);
        send_long(6'h1a, 1'b0, 16'd5, 1'b0);
        crc_gen_dis = 1'b0;
        finish_test("crc disabled");
        drop_link();
        send_long(6'h1e, 1'b0, 16'd19, 1'b1);
        finish_test("link drop");
        $display("Tests run %0d, failed checks %0d", tests, errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== crc_gen_lane.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "crc_lane_defs.svh"

module crc_gen_lane (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     crc_gen_dis,
    input  wire                     link_up,
    input  wire                     in_tunnel_mode_en,
    input  wire                     in_header_en,
    input  wire [`IDI_DT_W-1:0]     in_data_type,
    input  wire [`IDI_WC_W-1:0]     in_word_count,
    input  wire [`IDI_VC_W-1:0]     in_virtual_channel,
    input  wire [`IDI_DATA_W-1:0]   in_data,
    input  wire                     in_data_en,
    input  wire [`IDI_BE_W-1:0]     in_byte_en,
    output logic                    out_tunnel_mode_en,
    output logic                    out_header_en,
    output logic [`IDI_DT_W-1:0]    out_data_type,
    output logic [`IDI_WC_W-1:0]    out_word_count,
    output logic [`IDI_VC_W-1:0]    out_virtual_channel,
    output logic [`IDI_DATA_W-1:0]  out_data,
    output logic                    out_data_en,
    output logic [`IDI_BE_W-1:0]    out_byte_en,
    output logic                    pkt_crc_en,
    output logic [`CRC_W-1:0]       pkt_crc
);

    logic              load;
    logic              beat_stb;
    logic              crc_done;
    logic [`CRC_W-1:0] crc_value;

    idi_beat_if beat_bus ();
    crc_feed_if feed_bus ();

    assign beat_bus.tunnel_mode_en  = in_tunnel_mode_en;
    assign beat_bus.header_en       = in_header_en;
    assign beat_bus.data_type       = in_data_type;
    assign beat_bus.word_count      = in_word_count;
    assign beat_bus.virtual_channel = in_virtual_channel;
    assign beat_bus.data            = in_data;
    assign beat_bus.data_en         = in_data_en;
    assign beat_bus.byte_en         = in_byte_en;

    pkt_crc_fsm u_fsm (
        .clk      (clk),
        .rst_n    (rst_n),
        .link_up  (link_up),
        .beat     (beat_bus.snk),
        .feed     (feed_bus.drv_fsm),
        .load     (load),
        .beat_stb (beat_stb)
    );

    byte_remain_counter u_cnt (
        .clk      (clk),
        .rst_n    (rst_n),
        .load     (load),
        .beat_stb (beat_stb),
        .beat     (beat_bus.snk),
        .feed     (feed_bus.drv_cnt)
    );

    crc_data_prep u_prep (
        .beat (beat_bus.snk),
        .feed (feed_bus.drv_prep)
    );

    crc32_engine u_crc (
        .clk       (clk),
        .rst_n     (rst_n),
        .feed      (feed_bus.eng),
        .crc_done  (crc_done),
        .crc_value (crc_value)
    );

    // The engine pulse lines up with the first low out_header_en of the packet
    assign pkt_crc_en = ~crc_gen_dis & crc_done;
    assign pkt_crc    = crc_gen_dis ? '0 : crc_value;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_tunnel_mode_en  <= 1'b0;
            out_header_en       <= 1'b0;
            out_data_type       <= '0;
            out_word_count      <= '0;
            out_virtual_channel <= '0;
            out_data            <= '0;
            out_data_en         <= 1'b0;
            out_byte_en         <= '0;
        end else begin
            out_tunnel_mode_en  <= in_tunnel_mode_en;
            out_header_en       <= in_header_en;
            out_data_type       <= in_data_type;
            out_word_count      <= in_word_count;
            out_virtual_channel <= in_virtual_channel;
            out_data            <= in_data;
            out_data_en         <= in_data_en;
            out_byte_en         <= in_byte_en;
        end
    end

endmodule

`default_nettype wire

// ==== crc32_engine.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "crc_lane_defs.svh"

module crc32_engine (
    input  wire                    clk,
    input  wire                    rst_n,
    crc_feed_if.eng                feed,
    output logic                   crc_done,
    output logic [`CRC_W-1:0]      crc_value
);

    localparam int BEAT_BYTES = `IDI_DATA_W / 8;

    logic [`CRC_W-1:0] crc_acc;
    logic [`CRC_W-1:0] crc_next;

    // One byte through the reflected CRC-32, LSB first
    function automatic logic [`CRC_W-1:0] crc_byte(input logic [`CRC_W-1:0] crc_in,
                                                   input logic [7:0]        byte_in);
        logic [`CRC_W-1:0] c;
        c = crc_in ^ {{(`CRC_W-8){1'b0}}, byte_in};
        for (int b = 0; b < 8; b++) begin
            if (c[0])
                c = (c >> 1) ^ `CRC_POLY;
            else
                c = c >> 1;
        end
        return c;
    endfunction

    always_comb begin
        if (feed.slice == crc_lane_pkg::FIRST)
            crc_next = `CRC_INIT;
        else
            crc_next = crc_acc;
        for (int i = 0; i < BEAT_BYTES; i++) begin
            if (i < feed.byte_cnt)
                crc_next = crc_byte(crc_next, feed.data[i*8 +: 8]);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crc_acc   <= `CRC_INIT;
            crc_done  <= 1'b0;
            crc_value <= '0;
        end else begin
            crc_done <= feed.req && (feed.slice == crc_lane_pkg::LAST);
            if (feed.req) begin
                if (feed.slice == crc_lane_pkg::LAST) begin
                    // LAST has no bytes, so crc_next is the finished accumulator
                    crc_value <= crc_next ^ `CRC_XOR_OUT;
                    crc_acc   <= `CRC_INIT;
                end else begin
                    crc_acc <= crc_next;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== crc_data_prep.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "crc_lane_defs.svh"

module crc_data_prep (
    idi_beat_if.snk       beat,
    crc_feed_if.drv_prep  feed
);

    localparam int BEAT_BYTES = `IDI_DATA_W / 8;

    logic                   swap_en;
    logic [`IDI_DATA_W-1:0] swapped;
    logic [`IDI_DATA_W-1:0] ordered;

    assign swap_en = (beat.data_type == `DT_SWAP_A) || (beat.data_type == `DT_SWAP_B) ||
                     beat.tunnel_mode_en;

    always_comb begin
        for (int i = 0; i < BEAT_BYTES; i++) begin
            swapped[i*8 +: 8] = beat.data[(BEAT_BYTES-1-i)*8 +: 8];
        end
    end

    assign ordered = swap_en ? swapped : beat.data;

    // Byte 0 sits in bits 7:0, everything past the valid count is padding
    always_comb begin
        for (int i = 0; i < BEAT_BYTES; i++) begin
            if (i < feed.byte_cnt)
                feed.data[i*8 +: 8] = ordered[i*8 +: 8];
            else
                feed.data[i*8 +: 8] = 8'd0;
        end
    end

endmodule

`default_nettype wire

// ==== byte_remain_counter.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "crc_lane_defs.svh"

module byte_remain_counter (
    input  wire          clk,
    input  wire          rst_n,
    input  wire          load,
    input  wire          beat_stb,
    idi_beat_if.snk      beat,
    crc_feed_if.drv_cnt  feed
);

    localparam int BEAT_BYTES = `IDI_DATA_W / 8;

    logic [`IDI_WC_W-1:0] remain;

    // Full beats carry eight bytes, the tail beat carries what is left
    always_comb begin
        if (!beat_stb)
            feed.byte_cnt = '0;
        else if (remain >= `IDI_WC_W'(BEAT_BYTES))
            feed.byte_cnt = `BYTE_CNT_W'(BEAT_BYTES);
        else
            feed.byte_cnt = remain[`BYTE_CNT_W-1:0];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            remain <= '0;
        end else if (load) begin
            remain <= beat.word_count;
        end else if (beat_stb) begin
            remain <= remain - `IDI_WC_W'(feed.byte_cnt);
        end
    end

endmodule

`default_nettype wire

// ==== pkt_crc_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module pkt_crc_fsm (
    input  wire                clk,
    input  wire                rst_n,
    input  wire                link_up,
    idi_beat_if.snk            beat,
    crc_feed_if.drv_fsm        feed,
    output logic               load,
    output logic               beat_stb
);

    crc_lane_pkg::pkt_state_e state;
    crc_lane_pkg::pkt_state_e next_state;
    logic                     header_en_d1;
    logic                     long_hdr;
    logic                     payload;
    logic                     header_dn;
    logic                     first_slice;
    logic                     middle_slice;
    logic                     last_slice;

    // A long header is the rising header strobe with no data and a long data type
    assign long_hdr  = ~header_en_d1 & beat.header_en & ~beat.data_en & (|beat.data_type[5:2]);
    assign payload   = beat.header_en & beat.data_en;
    assign header_dn = header_en_d1 & ~beat.header_en;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            header_en_d1 <= 1'b0;
            state        <= crc_lane_pkg::SILENT;
        end else begin
            header_en_d1 <= beat.header_en;
            state        <= next_state;
        end
    end

    always_comb begin
        next_state = crc_lane_pkg::SILENT;
        if (link_up) begin
            case (state)
                crc_lane_pkg::SILENT: begin
                    next_state = crc_lane_pkg::IDLE;
                end
                crc_lane_pkg::IDLE: begin
                    if (long_hdr)
                        next_state = crc_lane_pkg::LONG_HEADER;
                    else if (payload)
                        next_state = crc_lane_pkg::LONG_DATA;
                    else
                        next_state = crc_lane_pkg::IDLE;
                end
                crc_lane_pkg::LONG_HEADER: begin
                    if (payload)
                        next_state = crc_lane_pkg::LONG_DATA;
                    else if (header_dn)
                        next_state = crc_lane_pkg::LONG_CRC;
                    else
                        next_state = crc_lane_pkg::LONG_HEADER;
                end
                crc_lane_pkg::LONG_DATA: begin
                    if (header_dn)
                        next_state = crc_lane_pkg::LONG_CRC;
                    else
                        next_state = crc_lane_pkg::LONG_DATA;
                end
                crc_lane_pkg::LONG_CRC: begin
                    next_state = crc_lane_pkg::IDLE;
                end
                default: begin
                    next_state = crc_lane_pkg::SILENT;
                end
            endcase
        end
    end

    assign first_slice  = (state == crc_lane_pkg::LONG_HEADER) &&
                          (next_state == crc_lane_pkg::LONG_DATA) && payload;
    assign middle_slice = (state == crc_lane_pkg::LONG_DATA) &&
                          (next_state == crc_lane_pkg::LONG_DATA) && payload;
    // The end cycle closes the packet, a link drop never reaches LONG_CRC
    assign last_slice   = ((state == crc_lane_pkg::LONG_DATA) ||
                           (state == crc_lane_pkg::LONG_HEADER)) &&
                          (next_state == crc_lane_pkg::LONG_CRC);

    assign feed.req   = first_slice | middle_slice | last_slice;
    assign feed.slice = first_slice ? crc_lane_pkg::FIRST :
                        last_slice  ? crc_lane_pkg::LAST  : crc_lane_pkg::MIDDLE;

    assign load     = (state == crc_lane_pkg::IDLE) && (next_state == crc_lane_pkg::LONG_HEADER);
    assign beat_stb = first_slice | middle_slice;

endmodule

`default_nettype wire

// ==== crc_lane_ifs.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "crc_lane_defs.svh"

// One input beat of the lane as seen by the CRC blocks
interface idi_beat_if;
    logic                   tunnel_mode_en;
    logic                   header_en;
    logic [`IDI_DT_W-1:0]   data_type;
    logic [`IDI_WC_W-1:0]   word_count;
    logic [`IDI_VC_W-1:0]   virtual_channel;
    logic [`IDI_DATA_W-1:0] data;
    logic                   data_en;
    logic [`IDI_BE_W-1:0]   byte_en;

    modport src (output tunnel_mode_en, header_en, data_type, word_count,
                 virtual_channel, data, data_en, byte_en);
    modport snk (input tunnel_mode_en, header_en, data_type, word_count,
                 virtual_channel, data, data_en, byte_en);
endinterface

// Slice request into the CRC engine, driven by three blocks
interface crc_feed_if;
    logic                      req;
    crc_lane_pkg::slice_kind_e slice;
    logic [`IDI_DATA_W-1:0]    data;
    logic [`BYTE_CNT_W-1:0]    byte_cnt;

    modport drv_fsm (output req, slice);
    modport drv_prep (input byte_cnt, output data);
    modport drv_cnt (output byte_cnt);
    modport eng (input req, slice, data, byte_cnt);
endinterface

`default_nettype wire

// ==== crc_lane_pkg.sv ====
`default_nettype none

package crc_lane_pkg;

    // Packet state machine of one lane
    typedef enum logic [2:0] {
        SILENT      = 3'd0,
        IDLE        = 3'd1,
        LONG_HEADER = 3'd2,
        LONG_DATA   = 3'd3,
        LONG_CRC    = 3'd4
    } pkt_state_e;

    // Kind of slice handed to the CRC engine
    typedef enum logic [1:0] {
        MIDDLE = 2'd0,
        FIRST  = 2'd1,
        LAST   = 2'd2
    } slice_kind_e;

endpackage

`default_nettype wire

// ==== crc_lane_defs.svh ====
`ifndef CRC_LANE_DEFS_SVH
`define CRC_LANE_DEFS_SVH

// Beat field widths of the lane
`define IDI_DATA_W  64
`define IDI_DT_W    6
`define IDI_WC_W    16
`define IDI_VC_W    4
`define IDI_BE_W    3

// Reflected CRC-32 as used on the link
`define CRC_W       32
`define CRC_POLY    32'hEDB88320
`define CRC_INIT    32'hFFFFFFFF
`define CRC_XOR_OUT 32'hFFFFFFFF

// Data types whose payload is byte-reversed ahead of the CRC
`define DT_SWAP_A   6'h1a
`define DT_SWAP_B   6'h1e

// Valid bytes per beat, 0 to 8
`define BYTE_CNT_W  4

`endif
